/* hdl/rns_config.svh */
`ifndef RNS_CONFIG_SVH
`define RNS_CONFIG_SVH

// ------------------------------------------------------------
// operand framing
// ------------------------------------------------------------
`define RNS_OPERAND_WIDTH 400
`define RNS_BEAT_WIDTH    40
`define RNS_BEATS         10

// ------------------------------------------------------------
// residue channels
// ------------------------------------------------------------
`define RNS_CHANNELS      4
`define RNS_RESIDUE_WIDTH 10
`define RNS_CHUNK_WIDTH   6

// one residue-width field per channel, channel 0 in the low field
`define RNS_MODULI {10'd523, 10'd521, 10'd509, 10'd503}

`endif

/* hdl/rns_pkg.sv */
`include "rns_config.svh"

package rns_pkg;

  // ------------------------------------------------------------
  // data types
  // ------------------------------------------------------------
  typedef logic [`RNS_OPERAND_WIDTH-1:0] operand_t;
  typedef logic [`RNS_BEAT_WIDTH-1:0]    beat_t;
  typedef logic [`RNS_RESIDUE_WIDTH-1:0] residue_t;

  // channel 0 sits in the low residue field
  typedef logic [`RNS_CHANNELS*`RNS_RESIDUE_WIDTH-1:0] residue_bus_t;

  typedef logic [`RNS_CHANNELS-1:0] divisor_mask_t;  // bit set when residue is zero

  // ------------------------------------------------------------
  // loader FSM
  // ------------------------------------------------------------
  typedef enum logic
  {
    loader_idle,
    loader_filling
  } loader_state_e;

endpackage

/* hdl/operand_loader.sv */
`timescale 1ns/1ps
`include "rns_config.svh"

module operand_loader (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              beat_valid,
  input  rns_pkg::beat_t    beat_data,
  output logic              operand_valid,
  output rns_pkg::operand_t operand
);

  localparam int OW    = `RNS_OPERAND_WIDTH;
  localparam int BW    = `RNS_BEAT_WIDTH;
  localparam int CNT_W = $clog2(`RNS_BEATS);

  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`RNS_BEATS - 1);

  rns_pkg::loader_state_e state;
  logic [CNT_W-1:0]       beat_count;
  logic                   load_pending;
  rns_pkg::operand_t      shift_reg;

  // ------------------------------------------------------------
  // beat counting FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state         <= rns_pkg::loader_idle;
      beat_count    <= '0;
      load_pending  <= 1'b0;
      operand_valid <= 1'b0;
    end
    else
    begin
      load_pending  <= 1'b0;
      operand_valid <= load_pending;  // one cycle after the last beat is sampled
      case (state)
        rns_pkg::loader_idle:
        begin
          if (beat_valid)
          begin
            state      <= rns_pkg::loader_filling;
            beat_count <= CNT_W'(1);
          end
        end
        rns_pkg::loader_filling:
        begin
          if (beat_valid)
          begin
            if (beat_count == LAST_BEAT)
            begin
              state        <= rns_pkg::loader_idle;
              beat_count   <= '0;
              load_pending <= 1'b1;
            end
            else
            begin
              beat_count <= beat_count + CNT_W'(1);
            end
          end
        end
        default:
        begin
          state      <= rns_pkg::loader_idle;
          beat_count <= '0;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // operand assembly
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (beat_valid)
      shift_reg <= {shift_reg[OW-BW-1:0], beat_data};  // first beat ends up on top
    if (load_pending)
      operand <= shift_reg;  // held here while the next operand fills
  end

endmodule

/* hdl/residue_channel.sv */
`timescale 1ns/1ps
`include "rns_config.svh"

module residue_channel #(
  parameter int MODULUS = 503
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              operand_valid,
  input  rns_pkg::operand_t operand,
  output logic              residue_valid,
  output rns_pkg::residue_t residue
);

  localparam int OW         = `RNS_OPERAND_WIDTH;
  localparam int RW         = `RNS_RESIDUE_WIDTH;
  localparam int CW         = `RNS_CHUNK_WIDTH;
  localparam int LUT_SIZE   = 1 << CW;
  localparam int NUM_CHUNKS = (OW + CW - 1) / CW;
  localparam int PAD        = NUM_CHUNKS * CW - OW;
  localparam int GROUP      = 8;
  localparam int NUM_GROUPS = (NUM_CHUNKS + GROUP - 1) / GROUP;
  localparam int PW         = RW + $clog2(GROUP);
  localparam int SW         = PW + $clog2(NUM_GROUPS);
  localparam int FOLDW      = RW + $clog2(SW - RW + 1);

  // enough steps to bring any folded sum below the modulus
  localparam int NSUB = FOLDW - $clog2(MODULUS + 1) + 1;

  typedef logic [LUT_SIZE-1:0][RW-1:0] lut_t;

  function automatic int pow2_mod(input int exponent);
    int acc;
    acc = 1 % MODULUS;
    for (int i = 0; i < exponent; i++)
      acc = (acc * 2) % MODULUS;
    return acc;
  endfunction

  // entry v holds v * 2^(chunk position) mod MODULUS
  function automatic lut_t build_lut(input int chunk);
    lut_t lut;
    int   weight;
    weight = pow2_mod(chunk * CW);
    for (int v = 0; v < LUT_SIZE; v++)
      lut[v] = RW'((v * weight) % MODULUS);
    return lut;
  endfunction

  logic [NUM_CHUNKS*CW-1:0]       operand_ext;
  wire  [NUM_CHUNKS-1:0][RW-1:0]  term_d;
  logic [NUM_CHUNKS-1:0][RW-1:0]  term_q;
  logic [NUM_GROUPS-1:0][PW-1:0]  psum_d;
  logic [NUM_GROUPS-1:0][PW-1:0]  psum_q;
  logic [SW-1:0]                  total;
  logic [FOLDW-1:0]               folded;
  logic [FOLDW-1:0]               reduced;
  logic                           valid_s1;
  logic                           valid_s2;

  assign operand_ext = {{PAD{1'b0}}, operand};  // top chunk is narrower

  // ------------------------------------------------------------
  // stage 1: chunk lookup
  // ------------------------------------------------------------
  for (genvar k = 0; k < NUM_CHUNKS; k++)
  begin : g_chunk
    localparam lut_t LUT = build_lut(k);
    assign term_d[k] = LUT[operand_ext[k*CW +: CW]];
  end

  always_ff @(posedge clk)
  begin
    term_q <= term_d;
  end

  // ------------------------------------------------------------
  // stage 2: partial sums over groups of eight terms
  // ------------------------------------------------------------
  always_comb
  begin
    for (int g = 0; g < NUM_GROUPS; g++)
    begin
      psum_d[g] = '0;
      for (int j = 0; j < GROUP; j++)
      begin
        if (g * GROUP + j < NUM_CHUNKS)
          psum_d[g] = psum_d[g] + PW'(term_q[g*GROUP + j]);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    psum_q <= psum_d;
  end

  // ------------------------------------------------------------
  // stage 3: final sum, fold and reduce
  // ------------------------------------------------------------
  always_comb
  begin
    total = '0;
    for (int g = 0; g < NUM_GROUPS; g++)
      total = total + SW'(psum_q[g]);

    // bits above the residue width come back in at 2^b mod MODULUS
    folded = FOLDW'(total[RW-1:0]);
    for (int b = RW; b < SW; b++)
    begin
      if (total[b])
        folded = folded + FOLDW'(pow2_mod(b));
    end

    reduced = folded;
    for (int s = NSUB - 1; s >= 0; s--)
    begin
      if (reduced >= FOLDW'(MODULUS << s))
        reduced = reduced - FOLDW'(MODULUS << s);
    end
  end

  always_ff @(posedge clk)
  begin
    residue <= reduced[RW-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_s1      <= 1'b0;
      valid_s2      <= 1'b0;
      residue_valid <= 1'b0;
    end
    else
    begin
      valid_s1      <= operand_valid;
      valid_s2      <= valid_s1;
      residue_valid <= valid_s2;
    end
  end

endmodule

/* hdl/residue_collector.sv */
`timescale 1ns/1ps
`include "rns_config.svh"

module residue_collector (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`RNS_CHANNELS-1:0] residue_valid,
  input  rns_pkg::residue_bus_t  residue_bus,
  output logic                   result_valid,
  output rns_pkg::residue_bus_t  residues,
  output rns_pkg::divisor_mask_t divisor_mask
);

  localparam int CH = `RNS_CHANNELS;
  localparam int RW = `RNS_RESIDUE_WIDTH;

  // ------------------------------------------------------------
  // result registers
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      result_valid <= 1'b0;
      residues     <= '0;
      divisor_mask <= '0;
    end
    else
    begin
      result_valid <= residue_valid[0];  // every channel has the same latency
      for (int i = 0; i < CH; i++)
      begin
        if (residue_valid[i])
        begin
          residues[i*RW +: RW] <= residue_bus[i*RW +: RW];
          divisor_mask[i]      <= (residue_bus[i*RW +: RW] == '0);  // modulus divides operand
        end
      end
    end
  end

endmodule

/* hdl/rns_converter_top.sv */
`timescale 1ns/1ps
`include "rns_config.svh"

module rns_converter_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   beat_valid,
  input  rns_pkg::beat_t         beat_data,
  output logic                   result_valid,
  output rns_pkg::residue_bus_t  residues,
  output rns_pkg::divisor_mask_t divisor_mask
);

  localparam int CH = `RNS_CHANNELS;
  localparam int RW = `RNS_RESIDUE_WIDTH;

  localparam logic [CH*RW-1:0] MODULI = `RNS_MODULI;

  logic                  operand_valid;
  rns_pkg::operand_t     operand;
  logic [CH-1:0]         residue_valid;
  rns_pkg::residue_bus_t residue_bus;

  operand_loader u_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .beat_valid    (beat_valid),
    .beat_data     (beat_data),
    .operand_valid (operand_valid),
    .operand       (operand)
  );

  // ------------------------------------------------------------
  // one channel per modulus, all fed the same operand
  // ------------------------------------------------------------
  for (genvar i = 0; i < CH; i++)
  begin : g_channel
    residue_channel #(
      .MODULUS (int'(MODULI[i*RW +: RW]))
    ) u_channel (
      .clk           (clk),
      .rst_n         (rst_n),
      .operand_valid (operand_valid),
      .operand       (operand),
      .residue_valid (residue_valid[i]),
      .residue       (residue_bus[i*RW +: RW])
    );
  end

  residue_collector u_collector (
    .clk           (clk),
    .rst_n         (rst_n),
    .residue_valid (residue_valid),
    .residue_bus   (residue_bus),
    .result_valid  (result_valid),
    .residues      (residues),
    .divisor_mask  (divisor_mask)
  );

endmodule

/* testbench/tb_rns_converter.sv */
`timescale 1ns/1ps
`include "rns_config.svh"

module tb_rns_converter;

  localparam int OW             = `RNS_OPERAND_WIDTH;
  localparam int BW             = `RNS_BEAT_WIDTH;
  localparam int NB             = `RNS_BEATS;
  localparam int CH             = `RNS_CHANNELS;
  localparam int RW             = `RNS_RESIDUE_WIDTH;
  localparam int LATENCY        = 5;    // last beat sampled to result_valid
  localparam int RESULT_TIMEOUT = 200;  // cycles to wait for one result

  localparam logic [CH*RW-1:0] MODULI = `RNS_MODULI;

  logic                   clk;
  logic                   rst_n;
  logic                   beat_valid;
  rns_pkg::beat_t         beat_data;
  logic                   result_valid;
  rns_pkg::residue_bus_t  residues;
  rns_pkg::divisor_mask_t divisor_mask;

  integer seed;
  int     cycle;              // number of rising edges so far
  int     error_count;
  int     tests_run;
  int     tests_failed;
  int     test_start_errors;
  int     sent_edges[$];      // edge that sampled each operand's last beat

  rns_converter_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat_valid   (beat_valid),
    .beat_data    (beat_data),
    .result_valid (result_valid),
    .residues     (residues),
    .divisor_mask (divisor_mask)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  function automatic rns_pkg::residue_bus_t ref_residues(input rns_pkg::operand_t op);
    rns_pkg::residue_bus_t bus;
    rns_pkg::operand_t     m;
    rns_pkg::operand_t     r;
    for (int i = 0; i < CH; i++)
    begin
      m = MODULI[i*RW +: RW];
      r = op % m;  // full-width remainder
      bus[i*RW +: RW] = r[RW-1:0];
    end
    return bus;
  endfunction

  function automatic rns_pkg::divisor_mask_t ref_mask(input rns_pkg::residue_bus_t bus);
    rns_pkg::divisor_mask_t mask;
    for (int i = 0; i < CH; i++)
      mask[i] = (bus[i*RW +: RW] == '0);
    return mask;
  endfunction

  function automatic rns_pkg::operand_t random_operand();
    rns_pkg::operand_t op;
    op = '0;
    for (int w = 0; w < (OW + 31) / 32; w++)
      op = {op[OW-33:0], 32'($random(seed))};
    return op;
  endfunction

  // ------------------------------------------------------------
  // compare and report
  // ------------------------------------------------------------
  task automatic check_residues(input string name, input rns_pkg::residue_bus_t expected,
                                input rns_pkg::residue_bus_t actual);
    if (actual !== expected)
    begin
      $display("Mismatch %s: residues expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_mask(input string name, input rns_pkg::divisor_mask_t expected,
                            input rns_pkg::divisor_mask_t actual);
    if (actual !== expected)
    begin
      $display("Mismatch %s: divisor mask expected %b, actual %b", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic start_test();
    test_start_errors = error_count;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count == test_start_errors)
      $display("test %s passed", name);
    else
    begin
      tests_failed++;
      $display("test %s failed, %0d errors", name, error_count - test_start_errors);
    end
  endtask

  // ------------------------------------------------------------
  // stimulus and response
  // ------------------------------------------------------------
  task automatic send_operand(input rns_pkg::operand_t op, input int max_gap);
    int gap;
    for (int b = NB - 1; b >= 0; b--)
    begin
      gap = (max_gap > 0) ? ($unsigned($random(seed)) % (max_gap + 1)) : 0;
      repeat (gap)
      begin
        @(posedge clk);
        beat_valid <= 1'b0;
      end
      @(posedge clk);
      beat_valid <= 1'b1;
      beat_data  <= op[b*BW +: BW];  // most significant beat first
    end
    sent_edges.push_back(cycle + 2);  // the DUT samples it on the next edge
  endtask

  task automatic end_beats();
    @(posedge clk);
    beat_valid <= 1'b0;
  endtask

  task automatic wait_result(output bit seen);
    int waited;
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < RESULT_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
      if (result_valid === 1'b1)
        seen = 1'b1;
    end
  endtask

  task automatic collect_result(input string name, input rns_pkg::operand_t op);
    bit                    seen;
    int                    sampled_at;
    rns_pkg::residue_bus_t expected;
    expected = ref_residues(op);
    wait_result(seen);
    sampled_at = (sent_edges.size() > 0) ? sent_edges.pop_front() : 0;
    if (!seen)
    begin
      $display("%s: result_valid never rose within %0d cycles", name, RESULT_TIMEOUT);
      error_count++;
    end
    else
    begin
      check_residues(name, expected, residues);
      check_mask(name, ref_mask(expected), divisor_mask);
      if (cycle != sampled_at + LATENCY)
      begin
        $display("Mismatch %s: latency expected %0d, actual %0d", name, LATENCY,
                 cycle - sampled_at);
        error_count++;
      end
    end
  endtask

  task automatic run_operand(input string name, input rns_pkg::operand_t op, input int max_gap);
    send_operand(op, max_gap);
    end_beats();
    collect_result(name, op);
  endtask

  task automatic check_idle(input string name);
    if (result_valid !== 1'b0)
    begin
      $display("Mismatch %s: result_valid expected 0, actual %b", name, result_valid);
      error_count++;
    end
    check_residues(name, '0, residues);
    check_mask(name, '0, divisor_mask);
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic test_reset();
    start_test();
    for (int k = 1; k <= 16; k++)
    begin
      @(posedge clk);
      if (k == 16)
        rst_n <= 1'b1;
      @(negedge clk);
      check_idle("reset_state");
    end
    repeat (4)
    begin
      @(negedge clk);
      check_idle("reset_state");
    end
    finish_test("reset_state");
  endtask

  task automatic test_small();
    rns_pkg::operand_t v;
    start_test();
    for (int k = 0; k < 8; k++)
    begin
      case (k)
        0: v = '0;
        1: v = 1;
        2: v = 2;
        3: v = 502;  // just below the smallest modulus
        default: v = $unsigned($random(seed)) % 503;
      endcase
      run_operand("small_operands", v, 0);
      check_residues("small_operands", {CH{v[RW-1:0]}}, residues);
      if (k == 0)
        check_mask("small_operands", '1, divisor_mask);
    end
    finish_test("small_operands");
  endtask

  task automatic test_multiples();
    rns_pkg::operand_t      prod;
    rns_pkg::operand_t      m;
    rns_pkg::operand_t      op;
    rns_pkg::divisor_mask_t expected_mask;
    start_test();
    prod = 1;
    for (int i = 0; i < CH; i++)
    begin
      m    = MODULI[i*RW +: RW];
      prod = prod * m;
    end
    for (int k = 0; k < 4; k++)
    begin
      op = prod * (random_operand() >> 64);  // stays well below 2^400
      run_operand("multiples", op, 0);
      check_mask("multiples", '1, divisor_mask);
    end
    for (int i = 0; i < CH; i++)
    begin
      m  = MODULI[i*RW +: RW];
      op = m * (random_operand() >> 16);
      run_operand("multiples", op, 0);
      expected_mask    = ref_mask(ref_residues(op));  // another modulus may divide it too
      expected_mask[i] = 1'b1;
      check_mask("multiples", expected_mask, divisor_mask);
    end
    finish_test("multiples");
  endtask

  task automatic test_random();
    start_test();
    run_operand("random_operands", '1, 0);
    for (int k = 1; k < 200; k++)
      run_operand("random_operands", random_operand(), 0);
    finish_test("random_operands");
  endtask

  task automatic test_back_to_back();
    rns_pkg::operand_t ops[3];
    start_test();
    for (int k = 0; k < 3; k++)
      ops[k] = random_operand();
    fork
      begin
        for (int k = 0; k < 3; k++)
          send_operand(ops[k], 0);
        end_beats();
      end
      begin
        for (int k = 0; k < 3; k++)
          collect_result("back_to_back", ops[k]);  // results in send order
      end
    join
    finish_test("back_to_back");
  endtask

  task automatic test_gaps();
    start_test();
    for (int k = 0; k < 4; k++)
      run_operand("beat_gaps", random_operand(), 4);
    finish_test("beat_gaps");
  endtask

  initial
  begin
    seed         = 32'h9f89da8f;
    clk          = 1'b0;
    rst_n        = 1'b0;
    beat_valid   = 1'b0;
    beat_data    = '0;
    cycle        = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;

    test_reset();
    test_small();
    test_multiples();
    test_random();
    test_back_to_back();
    test_gaps();

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* sources.f */
+incdir+hdl
hdl/rns_pkg.sv
hdl/operand_loader.sv
hdl/residue_channel.sv
hdl/residue_collector.sv
hdl/rns_converter_top.sv
testbench/tb_rns_converter.sv

/* Bender.yml */
package:
  name: rns_converter

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rns_pkg.sv
      - hdl/operand_loader.sv
      - hdl/residue_channel.sv
      - hdl/residue_collector.sv
      - hdl/rns_converter_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_rns_converter.sv
